// ==== hw/mole_pkg.sv ====
`default_nettype none

package mole_pkg;

	//////////////////////////////
	// basic types

	typedef logic [23:0] flash_addr_t; // playback address into flash
	typedef logic [2:0] mole_loc_t; // pad location 0..7

	// one bit per pad, upleft in the msb
	typedef struct packed {
		logic upleft;    // loc 0
		logic up;        // loc 1
		logic upright;   // loc 2
		logic left;      // loc 3
		logic right;     // loc 4
		logic downleft;  // loc 5
		logic down;      // loc 6
		logic downright; // loc 7
	} pad_buttons_t;

	// one recorded mole, 27 bits
	typedef struct packed {
		flash_addr_t flash_addr; // where in the track
		mole_loc_t   loc;        // which pad
	} mole_entry_t;

	//////////////////////////////
	// recorder fsm encoding

	typedef enum logic [2:0] {
		idle   = 3'd0, // waiting for diy mode
		arm    = 3'd1, // one cycle before listening
		listen = 3'd2, // taking pad presses
		hold   = 3'd3, // hold-off after a press
		check  = 3'd4, // full test
		done   = 3'd5  // table ready for lookup
	} record_state_e;

	//////////////////////////////
	// defaults for the top level

	localparam int default_max_items = 5; // table depth
	localparam int default_hold_seconds = 2; // one_hz ticks between moles
	localparam flash_addr_t default_track_end = 24'h06AC00; // end of background track

endpackage

`default_nettype wire

// ==== hw/pad_press_detector.sv ====
`timescale 1ns/1ns
`default_nettype none

// single pad rising edge -> one press with its location
module pad_press_detector
	import mole_pkg::*;
(
	input  logic         clock,
	input  logic         reset,
	input  pad_buttons_t pads,
	output logic         press_valid,
	output mole_loc_t    press_loc
);

	logic [7:0] prev_pads; // pad levels seen last cycle
	logic single_pad;      // exactly one pad down now

	always_ff @(posedge clock) begin
		if (reset) begin
			prev_pads <= '0; // all pads up out of reset
		end else begin
			prev_pads <= pads;
		end
	end

	//////////////////////////////
	// one hot decode

	always_comb begin
		single_pad = 1'b1;
		case (pads)
			8'b1000_0000: press_loc = 3'd0; // upleft
			8'b0100_0000: press_loc = 3'd1; // up
			8'b0010_0000: press_loc = 3'd2; // upright
			8'b0001_0000: press_loc = 3'd3; // left
			8'b0000_1000: press_loc = 3'd4; // right
			8'b0000_0100: press_loc = 3'd5; // downleft
			8'b0000_0010: press_loc = 3'd6; // down
			8'b0000_0001: press_loc = 3'd7; // downright
			default: begin
				press_loc = '0;
				single_pad = 1'b0; // none or several
			end
		endcase
	end

	// the pad must have been up last cycle
	assign press_valid = single_pad && ((pads & prev_pads) == 8'h00);

	//////////////////////////////
	// checks

	// decode table agrees with a plain one hot test
	single_when_valid: assert property (
		@(posedge clock) disable iff (reset)
		press_valid |-> $onehot(pads)
	);

endmodule

`default_nettype wire

// ==== hw/hold_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

// hold-off countdown, loaded on a press and paced by the 1 Hz tick
module hold_timer #(
	parameter int hold_seconds = 2
) (
	input  logic clock,
	input  logic reset,
	input  logic timer_start,   // pulse from the fsm
	input  logic one_hz_tick,   // single cycle pulse
	output logic timer_expired  // level, count is zero
);

	localparam int count_bits = $clog2(hold_seconds + 1);

	logic [count_bits-1:0] count; // seconds left

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0; // expired out of reset
		end else if (timer_start) begin
			count <= count_bits'(hold_seconds); // start beats a same-cycle tick
		end else if (one_hz_tick && count != '0) begin
			count <= count - 1'b1;
		end
	end

	assign timer_expired = (count == '0);

	//////////////////////////////
	// checks

	// load value is the ceiling
	count_in_range: assert property (
		@(posedge clock) disable iff (reset)
		count <= hold_seconds
	);

endmodule

`default_nettype wire

// ==== hw/mole_table.sv ====
`timescale 1ns/1ns
`default_nettype none

// recorded moles, one write port and a registered lookup port
module mole_table
	import mole_pkg::*;
#(
	parameter int max_items = 5,
	parameter int index_bits = 3
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  write_en,    // pulse from listen
	input  logic [index_bits-1:0] write_index,
	input  mole_entry_t           write_entry,
	input  logic                  read_en,     // level, high in done
	input  logic [index_bits-1:0] lookup_index,
	output mole_entry_t           lookup_entry
);

	mole_entry_t entries [max_items]; // payload only, no reset

	// write side
	always_ff @(posedge clock) begin
		if (write_en) begin
			entries[write_index] <= write_entry;
		end
	end

	// lookup, one cycle latency
	always_ff @(posedge clock) begin
		if (reset) begin
			lookup_entry <= '0;
		end else if (read_en) begin
			if (lookup_index < max_items) begin
				lookup_entry <= entries[lookup_index];
			end else begin
				lookup_entry <= '0; // past the table depth
			end
		end
		// otherwise hold the last lookup
	end

	//////////////////////////////
	// checks

	write_in_range: assert property (
		@(posedge clock) disable iff (reset)
		write_en |-> write_index < max_items
	);

endmodule

`default_nettype wire

// ==== hw/record_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

// diy recording sequence, item counter and ready flag
module record_fsm
	import mole_pkg::*;
#(
	parameter int max_items = 5,
	parameter int index_bits = 3,
	parameter flash_addr_t track_end = 24'h06AC00
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  diy_mode,      // level, low cancels
	input  flash_addr_t           flash_address, // current playback address
	input  logic                  press_valid,
	input  mole_loc_t             press_loc,
	input  logic                  timer_expired,
	output logic                  timer_start,
	output logic                  write_en,
	output logic [index_bits-1:0] write_index,
	output mole_entry_t           write_entry,
	output logic                  read_en,
	output logic [index_bits-1:0] item_count,
	output logic                  ready,
	output record_state_e         state
);

	record_state_e next_state;
	logic end_of_track; // playback ran past the track
	logic accept;       // press taken this cycle

	assign end_of_track = (flash_address >= track_end);

	// a press counts only in listen, before the end, with diy mode still up
	assign accept = (state == listen) && diy_mode && !end_of_track && press_valid;

	//////////////////////////////
	// next state

	always_comb begin
		next_state = state;
		unique case (state)
			idle: if (diy_mode) next_state = arm;
			arm: next_state = listen;
			listen: begin
				if (end_of_track) begin
					next_state = done; // track over, stop with what we have
				end else if (press_valid) begin
					next_state = hold;
				end
			end
			hold: if (timer_expired) next_state = check;
			check: next_state = (item_count >= max_items) ? done : arm;
			done: next_state = done; // stay until diy drops
			default: next_state = idle;
		endcase
		if (!diy_mode) begin
			next_state = idle; // cancel from anywhere
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	//////////////////////////////
	// count and ready

	always_ff @(posedge clock) begin
		if (reset) begin
			item_count <= '0;
			ready <= 1'b0;
		end else begin
			if (state == idle) begin
				item_count <= '0; // fresh table on every entry
				ready <= 1'b0;
			end else if (accept) begin
				item_count <= item_count + 1'b1;
			end
			if (state == done) begin
				ready <= 1'b1; // one cycle after entering done
			end
		end
	end

	// table and timer controls
	assign write_en = accept;
	assign timer_start = accept;
	assign write_index = item_count; // next free slot
	assign write_entry = '{flash_addr: flash_address, loc: press_loc};
	assign read_en = (state == done);

	//////////////////////////////
	// checks

	count_in_range: assert property (
		@(posedge clock) disable iff (reset)
		item_count <= max_items
	);

	// a write comes from listen and always lands in hold
	write_from_listen: assert property (
		@(posedge clock) disable iff (reset)
		write_en |-> (state == listen) ##1 (state == hold)
	);

endmodule

`default_nettype wire

// ==== hw/mole_recorder_top.sv ====
`timescale 1ns/1ns
`default_nettype none

// diy mole recorder, press detect + fsm + hold timer + table
module mole_recorder_top
	import mole_pkg::*;
#(
	parameter int max_items = default_max_items,
	parameter int index_bits = $clog2(max_items + 1), // count reaches max_items
	parameter int hold_seconds = default_hold_seconds,
	parameter flash_addr_t track_end = default_track_end
) (
	input  logic                  clock,
	input  logic                  reset,
	input  pad_buttons_t          pads,          // raw pad levels
	input  logic                  diy_mode,
	input  logic                  one_hz_tick,
	input  flash_addr_t           flash_address,
	input  logic [index_bits-1:0] lookup_index,
	output logic                  ready,
	output logic [index_bits-1:0] item_count,
	output mole_entry_t           lookup_entry,
	output record_state_e         state
);

	logic press_valid;
	mole_loc_t press_loc;
	logic timer_start;
	logic timer_expired;
	logic write_en;
	logic [index_bits-1:0] write_index;
	mole_entry_t write_entry;
	logic read_en;

	//////////////////////////////
	// blocks

	pad_press_detector i_press (
		.clock       (clock),
		.reset       (reset),
		.pads        (pads),
		.press_valid (press_valid),
		.press_loc   (press_loc)
	);

	hold_timer #(
		.hold_seconds (hold_seconds)
	) i_timer (
		.clock         (clock),
		.reset         (reset),
		.timer_start   (timer_start),
		.one_hz_tick   (one_hz_tick),
		.timer_expired (timer_expired)
	);

	record_fsm #(
		.max_items  (max_items),
		.index_bits (index_bits),
		.track_end  (track_end)
	) i_fsm (
		.clock         (clock),
		.reset         (reset),
		.diy_mode      (diy_mode),
		.flash_address (flash_address),
		.press_valid   (press_valid),
		.press_loc     (press_loc),
		.timer_expired (timer_expired),
		.timer_start   (timer_start),
		.write_en      (write_en),
		.write_index   (write_index),
		.write_entry   (write_entry),
		.read_en       (read_en),
		.item_count    (item_count),
		.ready         (ready),
		.state         (state)
	);

	mole_table #(
		.max_items  (max_items),
		.index_bits (index_bits)
	) i_table (
		.clock        (clock),
		.reset        (reset),
		.write_en     (write_en),
		.write_index  (write_index),
		.write_entry  (write_entry),
		.read_en      (read_en),
		.lookup_index (lookup_index),
		.lookup_entry (lookup_entry)
	);

endmodule

`default_nettype wire

// ==== dv/tb_model_checks.svh ====
`ifndef TB_MODEL_CHECKS_SVH
`define TB_MODEL_CHECKS_SVH

`default_nettype none

//////////////////////////////
// reference model state

record_state_e m_state;
logic [index_bits-1:0] m_count;
logic m_ready;
logic [7:0] m_prev_pads;       // pad levels from the last edge
int m_timer;                   // hold-off seconds left
mole_entry_t m_table [max_items];
logic [max_items-1:0] m_written; // slots with a known value
mole_entry_t m_lookup;
logic m_lookup_known;          // unwritten slots read as unknown
logic [31:0] lcg_state;

// lcg, upper bits only
function automatic int lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return {17'd0, lcg_state[30:16]};
endfunction

task automatic model_clear();
	m_state = idle;
	m_count = '0;
	m_ready = 1'b0;
	m_prev_pads = 8'h00;
	m_timer = 0;
	m_lookup = '0;
	m_lookup_known = 1'b1;
	m_written = '0;
endtask

// one clock edge of the recorder, from the inputs held over it
task automatic model_update();
	logic [7:0] pad_bits;
	logic single_new;
	logic past_end;
	logic accept;
	mole_loc_t loc;
	record_state_e nxt;
	int b;
	pad_bits = pads;
	// exactly one pad, and it was up last cycle
	single_new = ($countones(pad_bits) == 1) && ((pad_bits & m_prev_pads) == 8'h00);
	loc = '0;
	for (b = 0; b < 8; b++) begin
		if (pad_bits[7 - b]) begin
			loc = mole_loc_t'(b); // upleft sits in bit 7
		end
	end
	past_end = (flash_address >= track_end);
	accept = (m_state == listen) && diy_mode && !past_end && single_new;
	case (m_state)
		idle: nxt = diy_mode ? arm : idle;
		arm: nxt = listen;
		listen: nxt = past_end ? done : (single_new ? hold : listen);
		hold: nxt = (m_timer == 0) ? check : hold;
		check: nxt = (m_count >= max_items) ? done : arm;
		default: nxt = done;
	endcase
	if (!diy_mode) begin
		nxt = idle; // cancel wins everywhere
	end
	if (m_state == done) begin
		m_lookup_known = (lookup_index >= max_items) || m_written[lookup_index];
		m_lookup = (lookup_index < max_items) ? m_table[lookup_index] : '0;
	end
	if (accept) begin
		m_table[m_count] = '{flash_addr: flash_address, loc: loc};
		m_written[m_count] = 1'b1;
	end
	if (m_state == idle) begin
		m_count = '0;
		m_ready = 1'b0;
	end else if (accept) begin
		m_count = m_count + 1'b1;
	end
	if (m_state == done) begin
		m_ready = 1'b1;
	end
	if (accept) begin
		m_timer = hold_seconds;
	end else if (one_hz_tick && m_timer != 0) begin
		m_timer = m_timer - 1;
	end
	m_prev_pads = pad_bits;
	m_state = nxt;
endtask

//////////////////////////////
// compares, one per result kind

task automatic check_entry(string name, mole_entry_t exp, mole_entry_t act);
	if (act !== exp) begin
		$display("** Error %s: entry expected %h/%0d, actual %h/%0d", name,
			exp.flash_addr, exp.loc, act.flash_addr, act.loc);
		$display("Regression failed");
		$fatal(1, "lookup entry mismatch");
	end
endtask

task automatic check_count(string name, logic [index_bits-1:0] exp, logic [index_bits-1:0] act);
	if (act !== exp) begin
		$display("** Error %s: item_count expected %0d, actual %0d", name, exp, act);
		$display("Regression failed");
		$fatal(1, "item count mismatch");
	end
endtask

task automatic check_state(string name, record_state_e exp, record_state_e act);
	if (act !== exp) begin
		$display("** Error %s: state expected %s, actual %s (%0d)", name,
			exp.name(), act.name(), act);
		$display("Regression failed");
		$fatal(1, "state mismatch");
	end
endtask

task automatic check_ready(string name, logic exp, logic act);
	if (act !== exp) begin
		$display("** Error %s: ready expected %b, actual %b", name, exp, act);
		$display("Regression failed");
		$fatal(1, "ready mismatch");
	end
endtask

task automatic compare_outputs(string name);
	check_state(name, m_state, state);
	check_count(name, m_count, item_count);
	check_ready(name, m_ready, ready);
	if (m_lookup_known) begin
		check_entry(name, m_lookup, lookup_entry);
	end
endtask

`default_nettype wire

`endif

// ==== dv/tb_mole_recorder.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mole_recorder
	import mole_pkg::*;
();

	localparam int max_items = default_max_items;
	localparam int index_bits = $clog2(max_items + 1);
	localparam int hold_seconds = default_hold_seconds;
	localparam flash_addr_t track_end = default_track_end;

	//////////////////////////////
	// test lengths in cycles

	localparam int reset_cycles = 3;
	localparam int wait_limit = 400; // longest wait for one state
	localparam int len_full = wait_limit + max_items + 4;
	localparam int len_end = 2 * wait_limit + max_items + 6;
	localparam int len_cancel = 5 * (wait_limit + 2) + 2;
	localparam int timeout_cycles = 4 * (reset_cycles + len_full + len_end + len_cancel);

	logic clock;
	logic reset;
	pad_buttons_t pads;
	logic diy_mode;
	logic one_hz_tick;
	flash_addr_t flash_address;
	logic [index_bits-1:0] lookup_index;
	logic ready;
	logic [index_bits-1:0] item_count;
	mole_entry_t lookup_entry;
	record_state_e state;

	int cycle_count = 0;
	record_state_e cancel_targets [5] = '{arm, listen, hold, check, done};

	`include "tb_model_checks.svh"

	mole_recorder_top #(
		.max_items    (max_items),
		.index_bits   (index_bits),
		.hold_seconds (hold_seconds),
		.track_end    (track_end)
	) i_dut (
		.clock         (clock),
		.reset         (reset),
		.pads          (pads),
		.diy_mode      (diy_mode),
		.one_hz_tick   (one_hz_tick),
		.flash_address (flash_address),
		.lookup_index  (lookup_index),
		.ready         (ready),
		.item_count    (item_count),
		.lookup_entry  (lookup_entry),
		.state         (state)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("run did not finish within %0d cycles", timeout_cycles);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////
	// stimulus helpers

	// edge for dut and model, compare on the falling edge
	task automatic advance_cycle(string name);
		@(posedge clock);
		model_update();
		@(negedge clock);
		compare_outputs(name);
	endtask

	task automatic randomize_inputs(logic allow_end);
		int r;
		r = lcg_next() % 16;
		one_hz_tick = (lcg_next() % 4 == 0);
		if (r < 6) begin
			pads = '0; // gap
		end else if (r < 12) begin
			pads = pad_buttons_t'(8'h80 >> (lcg_next() % 8)); // one pad
		end else if (r < 14) begin
			pads = pad_buttons_t'(8'(lcg_next())); // mostly several pads
		end
		// else pads held as they are
		flash_address = flash_address + flash_addr_t'(lcg_next() % 1024);
		if (allow_end && (lcg_next() % 8 == 0)) begin
			flash_address = track_end + flash_addr_t'(lcg_next() % 4);
		end
		lookup_index = index_bits'(lcg_next());
	endtask

	task automatic run_until_state(record_state_e target, string name, logic allow_end);
		int n;
		n = 0;
		while (state != target) begin
			if (n == wait_limit) begin
				$display("%s: state %s not reached in %0d cycles", name, target.name(), n);
				$display("Regression failed");
				$fatal(1, "state wait timed out");
			end
			randomize_inputs(allow_end);
			advance_cycle(name);
			n++;
		end
	endtask

	// drop diy mode, idle clears count and ready a cycle later
	task automatic cancel_diy(string name);
		diy_mode = 1'b0;
		advance_cycle(name);
		check_state(name, idle, state);
		advance_cycle(name);
		check_count(name, '0, item_count);
		check_ready(name, 1'b0, ready);
	endtask

	task automatic read_back_table(string name);
		int i;
		pads = '0;
		one_hz_tick = 1'b0;
		for (i = 0; i < m_count; i++) begin
			lookup_index = i[index_bits-1:0];
			advance_cycle(name);
			check_entry(name, m_table[i], lookup_entry); // one cycle after the index
		end
	endtask

	//////////////////////////////
	// test sequence

	initial begin
		lcg_state = 32'd57056;
		reset = 1'b1;
		pads = '0;
		diy_mode = 1'b0;
		one_hz_tick = 1'b0;
		flash_address = '0;
		lookup_index = '0;
		model_clear();
		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;
		compare_outputs("reset");

		// random presses until the table fills
		diy_mode = 1'b1;
		run_until_state(done, "record_full", 1'b0);
		advance_cycle("record_full"); // ready trails done
		check_ready("record_full", 1'b1, ready);
		check_count("record_full", index_bits'(max_items), item_count);
		read_back_table("record_full");

		// one press, then the track runs out
		cancel_diy("end_of_track");
		flash_address = flash_addr_t'(lcg_next());
		diy_mode = 1'b1;
		run_until_state(hold, "end_of_track", 1'b0);
		run_until_state(listen, "end_of_track", 1'b0);
		pads = '0;
		flash_address = track_end; // exactly at the end
		advance_cycle("end_of_track");
		check_state("end_of_track", done, state);
		advance_cycle("end_of_track");
		check_ready("end_of_track", 1'b1, ready);
		read_back_table("end_of_track");

		// drop diy mode in each state
		cancel_diy("cancel");
		foreach (cancel_targets[t]) begin
			flash_address = flash_addr_t'(lcg_next()); // well below the end
			diy_mode = 1'b1;
			run_until_state(cancel_targets[t], "cancel", cancel_targets[t] == done);
			cancel_diy("cancel");
		end

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+dv
hw/mole_pkg.sv
hw/pad_press_detector.sv
hw/hold_timer.sv
hw/mole_table.sv
hw/record_fsm.sv
hw/mole_recorder_top.sv
dv/tb_mole_recorder.sv

// ==== Bender.yml ====
package:
  name: mole_recorder

sources:
  - files:
      - hw/mole_pkg.sv
      - hw/pad_press_detector.sv
      - hw/hold_timer.sv
      - hw/mole_table.sv
      - hw/record_fsm.sv
      - hw/mole_recorder_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_mole_recorder.sv
